// ==== Bender.yml ====
package:
  name: fpumiscwb

sources:
  # RTL in compile order
  - verilog/fpuMiscPkg.sv
  - verilog/fpUnpack.sv
  - verilog/fsgninj.sv
  - verilog/fcmp.sv
  - verilog/fclassify.sv
  - verilog/fpuMiscWb.sv

  # Testbench and bound properties
  - target: test
    files:
      - dv/fpuMiscWb_props.sv
      - dv/fpuMiscWbTb.sv

// ==== dv/fpuMiscWbTb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the FPU Wishbone slave. Drives operands over the
// bus, checks results and NV against a reference model, and
// prints one line per test and a closing count line
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpuMiscWbTb import fpuMiscPkg::*; ();

	localparam int ACK_TIMEOUT = 20;
	localparam int NSPEC = 11;

	logic clk = 1'b0;
	logic rstN;
	wbReq_t wbReq;
	logic wbAck;
	logic [WBW-1:0] wbDatOut;

	logic [31:0] lcgState = 32'd82132;
	string curTest;
	int checkCount = 0;
	int errCount = 0;
	int testChecks;
	int testErrs;

	fpuMiscWb i_dut (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbAck(wbAck), .wbDatOut(wbDatOut));

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Special encodings in the same order for both formats
	// Index 10 is a signaling NaN for doubles and a broken box for singles
	function automatic logic [63:0] specialVal(input int idx, input logic isD);
		logic [63:0] d [NSPEC];
		logic [63:0] s [NSPEC];
		d = '{64'h0, 64'h8000_0000_0000_0000, 64'h7FF0_0000_0000_0000,
			64'hFFF0_0000_0000_0000, 64'h7FF8_0000_0000_0000, 64'h7FF4_0000_0000_0000,
			64'h3FF0_0000_0000_0000, 64'hBFF0_0000_0000_0000, 64'h0000_0000_0000_0001,
			64'h8008_0000_0000_0000, 64'h7FF0_0000_0000_0001};
		// Single values are boxed except the last, which breaks the box
		s = '{64'hFFFF_FFFF_0000_0000, 64'hFFFF_FFFF_8000_0000, 64'hFFFF_FFFF_7F80_0000,
			64'hFFFF_FFFF_FF80_0000, 64'hFFFF_FFFF_7FC0_0000, 64'hFFFF_FFFF_7FA0_0000,
			64'hFFFF_FFFF_3F80_0000, 64'hFFFF_FFFF_BF80_0000, 64'hFFFF_FFFF_0000_0001,
			64'hFFFF_FFFF_807F_FFFF, 64'h0000_0000_3F80_0000};
		return isD ? d[idx] : s[idx];
	endfunction

	// About one operand in four is a special encoding
	function automatic logic [63:0] randOperand(input logic isD);
		logic [31:0] r;
		r = lcgNext();
		if (r[1:0] == 2'b00) begin
			return specialVal(int'(r[15:8]) % NSPEC, isD);
		end
		return isD ? {lcgNext(), lcgNext()} : {32'hFFFF_FFFF, lcgNext()};
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic logic [63:0] unboxVal(input logic [63:0] v, input logic isD);
		if (!isD && v[63:32] != 32'hFFFF_FFFF) begin
			return 64'hFFFF_FFFF_7FC0_0000;
		end
		return v;
	endfunction

	// RISC-V fclass mask, also used to get the NaN and zero flags
	function automatic logic [9:0] classOf(input logic [63:0] v, input logic isD);
		logic sgn;
		logic eMax;
		logic eZero;
		logic mZero;
		logic quiet;
		logic [9:0] cls;
		sgn = isD ? v[63] : v[31];
		eMax = isD ? &v[62:52] : &v[30:23];
		eZero = isD ? ~|v[62:52] : ~|v[30:23];
		mZero = isD ? ~|v[51:0] : ~|v[22:0];
		quiet = isD ? v[51] : v[22];
		cls = '0;
		if (eMax && !mZero) cls[quiet ? 9 : 8] = 1'b1;
		else if (eMax) cls[sgn ? 0 : 7] = 1'b1;
		else if (eZero && mZero) cls[sgn ? 3 : 4] = 1'b1;
		else if (eZero) cls[sgn ? 2 : 5] = 1'b1;
		else cls[sgn ? 1 : 6] = 1'b1;
		return cls;
	endfunction

	// Strict order on non-NaN values with -0 below +0
	function automatic logic lessThan(input logic [63:0] a, input logic [63:0] b, input logic isD);
		logic sa;
		logic sb;
		logic [62:0] ma;
		logic [62:0] mb;
		sa = isD ? a[63] : a[31];
		sb = isD ? b[63] : b[31];
		ma = isD ? a[62:0] : {32'b0, a[30:0]};
		mb = isD ? b[62:0] : {32'b0, b[30:0]};
		if (sa != sb) return sa;
		return sa ? (ma > mb) : (ma < mb);
	endfunction

	// Returns {NV, result}
	function automatic logic [64:0] refResult(input fpOp_t op, input logic isD,
			input logic [63:0] x, input logic [63:0] y);
		logic [63:0] xu;
		logic [63:0] yu;
		logic [63:0] res;
		logic [9:0] cx;
		logic [9:0] cy;
		logic anyNaN;
		logic bothNaN;
		logic lt;
		logic eq;
		logic s;
		logic nv;
		xu = unboxVal(x, isD);
		yu = unboxVal(y, isD);
		cx = classOf(xu, isD);
		cy = classOf(yu, isD);
		anyNaN = |{cx[9:8], cy[9:8]};
		bothNaN = |cx[9:8] && |cy[9:8];
		eq = ((cx[3] | cx[4]) & (cy[3] | cy[4])) | (isD ? xu == yu : xu[31:0] == yu[31:0]);
		lt = lessThan(xu, yu, isD) & ~((cx[3] | cx[4]) & (cy[3] | cy[4]));
		res = '0;
		nv = 1'b0;
		case (op)
			OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: begin
				s = isD ? yu[63] : yu[31];
				if (op == OP_FSGNJN) s = ~s;
				if (op == OP_FSGNJX) s = s ^ (isD ? xu[63] : xu[31]);
				res = isD ? {s, xu[62:0]} : {32'hFFFF_FFFF, s, xu[30:0]};
			end
			OP_FEQ: begin
				res[0] = eq & ~anyNaN;
				nv = cx[8] | cy[8];
			end
			OP_FLT, OP_FLE: begin
				res[0] = (lt | (eq & (op == OP_FLE))) & ~anyNaN;
				nv = anyNaN;
			end
			OP_FMIN, OP_FMAX: begin
				nv = cx[8] | cy[8];
				if (bothNaN) res = isD ? 64'h7FF8_0000_0000_0000 : 64'hFFFF_FFFF_7FC0_0000;
				else if (|cx[9:8]) res = yu;
				else if (|cy[9:8]) res = xu;
				else res = (lessThan(xu, yu, isD) == (op == OP_FMIN)) ? xu : yu;
			end
			OP_FCLASS: res = {54'b0, cx};
			default: res = '0;
		endcase
		return {nv, res};
	endfunction

	////////////////////////////////////////////////////////////
	// Bus tasks and checking
	////////////////////////////////////////////////////////////

	task automatic waitAck();
		int cnt;
		cnt = 0;
		while (!wbAck && cnt < ACK_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!wbAck) begin
			$display("Timeout: the DUT gave no ack within %0d cycles", ACK_TIMEOUT);
			$display("TEST FAIL");
			$finish;
		end
	endtask

	task automatic busWrite(input logic [3:0] adr, input logic [31:0] dat);
		@(negedge clk);
		wbReq = '{adr: adr, dat: dat, we: 1'b1, cyc: 1'b1, stb: 1'b1};
		waitAck();
		wbReq = '0;
	endtask

	// Data is taken on the falling edge while ack is high
	task automatic busRead(input logic [3:0] adr, output logic [31:0] dat);
		@(negedge clk);
		wbReq = '{adr: adr, dat: 32'h0, we: 1'b0, cyc: 1'b1, stb: 1'b1};
		waitAck();
		dat = wbDatOut;
		wbReq = '0;
	endtask

	task automatic checkValue(input string tag, input logic [63:0] expVal,
			input logic [63:0] actVal);
		checkCount++;
		valueMatch: assert (actVal === expVal) else begin
			$display("MISMATCH %s %s: expected %h actual %h", curTest, tag, expVal, actVal);
			errCount++;
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testChecks = checkCount;
		testErrs = errCount;
	endtask

	task automatic endTest();
		$display("%s: %0d checks, %0d errors", curTest, checkCount - testChecks,
			errCount - testErrs);
	endtask

	// Load both operands, launch, then read the result and NV back
	task automatic runOp(input fpOp_t op, input logic isD, input logic [63:0] x,
			input logic [63:0] y);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] fl;
		logic [64:0] expVal;
		string tag;
		expVal = refResult(op, isD, x, y);
		tag = $sformatf("%s x=%h y=%h", op.name(), x, y);
		busWrite(R_XLO, x[31:0]);
		busWrite(R_XHI, x[63:32]);
		busWrite(R_YLO, y[31:0]);
		busWrite(R_YHI, y[63:32]);
		busWrite(R_CTRL, {27'b0, isD, op});
		busRead(R_RESLO, lo);
		busRead(R_RESHI, hi);
		busRead(R_FLAGS, fl);
		checkValue({tag, " res"}, expVal[63:0], {hi, lo});
		checkValue({tag, " nv"}, {63'b0, expVal[64]}, {32'b0, fl});
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rd;
		logic [31:0] lo;
		logic [31:0] hi;
		logic [31:0] r;
		logic [63:0] a;
		logic [63:0] b;
		fpOp_t cmpOps [3];
		int total;
		cmpOps = '{OP_FEQ, OP_FLT, OP_FLE};
		wbReq = '0;
		rstN = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Control reads back OP_FSGNJ with FMT_S, which is zero like the rest
		startTest("reset");
		for (int adr = 0; adr < 16; adr++) begin
			busRead(adr[3:0], rd);
			checkValue($sformatf("adr=%0d", adr), 64'h0, {32'b0, rd});
		end
		endTest();

		for (int f = 0; f < 2; f++) begin
			startTest(f ? "sgnj_d" : "sgnj_s");
			for (int i = 0; i < 40; i++) begin
				a = randOperand(f[0]);
				b = randOperand(f[0]);
				runOp(OP_FSGNJ, f[0], a, b);
				runOp(OP_FSGNJN, f[0], a, b);
				runOp(OP_FSGNJX, f[0], a, b);
			end
			endTest();
		end

		// Upper word cleared or partly set breaks the box
		startTest("nanbox");
		for (int k = 0; k <= 8; k++) begin
			r = lcgNext();
			a = {16'h0, r[15:0], lcgNext()};
			runOp(fpOp_t'(k), 1'b0, a, randOperand(1'b0));
			runOp(fpOp_t'(k), 1'b0, randOperand(1'b0), a);
		end
		endTest();

		// Every pair of special encodings through the compares and min/max
		for (int f = 0; f < 2; f++) begin
			startTest(f ? "cmp_d" : "cmp_s");
			for (int i = 0; i < NSPEC; i++) begin
				for (int j = 0; j < NSPEC; j++) begin
					foreach (cmpOps[k]) runOp(cmpOps[k], f[0], specialVal(i, f[0]),
						specialVal(j, f[0]));
				end
			end
			endTest();
			startTest(f ? "minmax_d" : "minmax_s");
			for (int i = 0; i < NSPEC; i++) begin
				for (int j = 0; j < NSPEC; j++) begin
					runOp(OP_FMIN, f[0], specialVal(i, f[0]), specialVal(j, f[0]));
					runOp(OP_FMAX, f[0], specialVal(i, f[0]), specialVal(j, f[0]));
				end
			end
			endTest();
		end

		startTest("fclass");
		for (int f = 0; f < 2; f++) begin
			for (int i = 0; i < NSPEC; i++) runOp(OP_FCLASS, f[0], specialVal(i, f[0]), 64'h0);
			for (int i = 0; i < 20; i++) begin
				a = f ? {lcgNext(), lcgNext()} : {32'hFFFF_FFFF, lcgNext()};
				runOp(OP_FCLASS, f[0], a, 64'h0);
			end
		end
		// Operand writes alone must not disturb the held +inf class
		runOp(OP_FCLASS, 1'b1, 64'h7FF0_0000_0000_0000, 64'h0);
		busWrite(R_XLO, 32'h0);
		busWrite(R_XHI, 32'h8000_0000);
		busRead(R_RESLO, lo);
		busRead(R_RESHI, hi);
		checkValue("hold", 64'h80, {hi, lo});
		endTest();

		total = errCount + i_dut.i_props.failCount;
		$display("checks %0d, mismatches %0d, assertion failures %0d", checkCount, errCount,
			i_dut.i_props.failCount);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== dv/fpuMiscWb_props.sv ====
////////////////////////////////////////////////////////////
// Bus and result properties for the FPU Wishbone slave. Bound to
// every fpuMiscWb instance; the testbench reads failCount at the end
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpuMiscWbProps import fpuMiscPkg::*; (
	input logic clk,
	input logic rstN,
	input wbReq_t wbReq,
	input logic wbAck,
	input logic launch,
	input fpOp_t op,
	input fpFmt_t fmt,
	input logic [FLEN-1:0] resReg
);

	// Number of assertion failures seen so far
	int failCount = 0;

	// Ack is a single-cycle pulse
	ackOnePulse: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
		else begin
			failCount++;
			$error("ack stayed high for more than one cycle");
		end

	// Ack only follows a cycle in which cyc and stb were both high
	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(wbAck) |-> $past(wbReq.cyc && wbReq.stb))
		else begin
			failCount++;
			$error("ack rose without a request from the master");
		end

	// Leaving reset the slave is idle
	ackLowAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !wbAck)
		else begin
			failCount++;
			$error("ack was high right after reset");
		end

	// Sign injection and min/max give register values, so a single
	// result must come back NaN-boxed
	singleBoxed: assert property (@(posedge clk) disable iff (!rstN)
		(launch && fmt == FMT_S && op inside {OP_FSGNJ, OP_FSGNJN, OP_FSGNJX, OP_FMIN, OP_FMAX})
		|=> (&resReg[FLEN-1:SLEN]))
		else begin
			failCount++;
			$error("single result without all ones in the upper word");
		end

endmodule

bind fpuMiscWb fpuMiscWbProps i_props (
	.clk(clk),
	.rstN(rstN),
	.wbReq(wbReq),
	.wbAck(wbAck),
	.launch(launch),
	.op(op),
	.fmt(fmt),
	.resReg(resReg)
);

// ==== fpuMiscWb.f ====
verilog/fpuMiscPkg.sv
verilog/fpUnpack.sv
verilog/fsgninj.sv
verilog/fcmp.sv
verilog/fclassify.sv
verilog/fpuMiscWb.sv
dv/fpuMiscWb_props.sv
dv/fpuMiscWbTb.sv

// ==== verilog/fclassify.sv ====
////////////////////////////////////////////////////////////
// fclass result, a one-hot ten-bit class mask built from the
// unpacked sign and special-value flags
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fclassify import fpuMiscPkg::*; (
	input fpOperand_t x,
	output logic [FLEN-1:0] classRes
);

	logic [9:0] classMask;

	// Priority runs NaN, inf, zero, subnormal, then normal
	always_comb begin
		classMask = '0;
		if (x.isNaN) begin
			// Bit 8 signaling, bit 9 quiet
			if (x.isSNaN) begin
				classMask[8] = 1'b1;
			end else begin
				classMask[9] = 1'b1;
			end
		end else if (x.isInf) begin
			classMask[x.sign ? 0 : 7] = 1'b1;
		end else if (x.isZero) begin
			classMask[x.sign ? 3 : 4] = 1'b1;
		end else if (x.isSubnorm) begin
			classMask[x.sign ? 2 : 5] = 1'b1;
		end else begin
			// Everything left is a normal number
			classMask[x.sign ? 1 : 6] = 1'b1;
		end
	end

	// Upper bits of the destination are zero
	assign classRes = {{(FLEN-10){1'b0}}, classMask};

endmodule

// ==== verilog/fcmp.sv ====
////////////////////////////////////////////////////////////
// Compare and min/max unit. Handles feq, flt, fle, fmin and fmax
// with the RISC-V NaN and signed-zero rules and raises invalid
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fcmp import fpuMiscPkg::*; (
	input fpOperand_t x,
	input fpOperand_t y,
	input cmpOp_t cmpOp,
	output logic [FLEN-1:0] cmpRes,
	output logic invalid
);

	logic [FLEN-2:0] xMag;
	logic [FLEN-2:0] yMag;
	logic magLt;
	logic magGt;
	logic bothZero;
	logic xBelowY;
	logic isEq;
	logic isLt;
	logic anyNaN;
	logic anySNaN;
	logic [FLEN-1:0] cNaN;

	////////////////////////////////////////////////////////////
	// Ordering
	////////////////////////////////////////////////////////////

	// Exponent over mantissa is monotone in magnitude in both layouts
	assign xMag = {x.exponent, x.mantissa};
	assign yMag = {y.exponent, y.mantissa};
	assign magLt = xMag < yMag;
	assign magGt = xMag > yMag;
	assign bothZero = x.isZero & y.isZero;

	// Strict signed order, where -0 sits below +0
	assign xBelowY = (x.sign != y.sign) ? x.sign : (x.sign ? magGt : magLt);

	// Comparisons see +0 and -0 as equal
	assign isEq = bothZero | ((x.sign == y.sign) & (xMag == yMag));
	assign isLt = xBelowY & ~bothZero;

	assign anyNaN = x.isNaN | y.isNaN;
	assign anySNaN = x.isSNaN | y.isSNaN;

	// A double NaN has its exponent MSB set, a single NaN never does
	assign cNaN = x.exponent[EXP_W-1] ? CNAN_D : CNAN_S;

	////////////////////////////////////////////////////////////
	// Result and invalid flag
	////////////////////////////////////////////////////////////

	always_comb begin
		cmpRes = '0;
		invalid = 1'b0;
		case (cmpOp)
			CMP_EQ: begin
				// Quiet compare, NV only on a signaling NaN
				cmpRes[0] = isEq & ~anyNaN;
				invalid = anySNaN;
			end
			CMP_LT: begin
				cmpRes[0] = isLt & ~anyNaN;
				invalid = anyNaN;
			end
			CMP_LE: begin
				cmpRes[0] = (isLt | isEq) & ~anyNaN;
				invalid = anyNaN;
			end
			CMP_MIN, CMP_MAX: begin
				if (x.isNaN & y.isNaN) begin
					cmpRes = cNaN;
				end else if (x.isNaN) begin
					cmpRes = y.boxed;
				end else if (y.isNaN) begin
					cmpRes = x.boxed;
				end else if (cmpOp == CMP_MIN) begin
					cmpRes = xBelowY ? x.boxed : y.boxed;
				end else begin
					cmpRes = xBelowY ? y.boxed : x.boxed;
				end
				invalid = anySNaN;
			end
			default: begin
				cmpRes = '0;
				invalid = 1'b0;
			end
		endcase
	end

endmodule

// ==== verilog/fpUnpack.sv ====
////////////////////////////////////////////////////////////
// Unpacks one 64-bit FP register into sign, exponent, mantissa
// and special-value flags, checking the NaN-box for singles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpUnpack import fpuMiscPkg::*; (
	input logic [FLEN-1:0] src,
	input fpFmt_t fmt,
	output fpOperand_t opnd
);

	logic boxOk;
	logic [FLEN-1:0] val;
	logic sgn;
	logic [EXP_W-1:0] expo;
	logic [MAN_W-1:0] mant;
	logic expMax;
	logic expZero;
	logic mantZero;

	// A single is only valid when the upper word is all ones
	assign boxOk = &src[FLEN-1:SLEN];

	// Broken boxes read as the canonical single NaN
	assign val = (fmt == FMT_S && !boxOk) ? CNAN_S : src;

	////////////////////////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////////////////////////

	always_comb begin
		if (fmt == FMT_D) begin
			sgn = val[FLEN-1];
			expo = val[FLEN-2:MAN_W];
			mant = val[MAN_W-1:0];
			expMax = &val[FLEN-2:MAN_W];
		end else begin
			// Exponent right-aligned, mantissa left-aligned
			sgn = val[SLEN-1];
			expo = {{(EXP_W-SEXP_W){1'b0}}, val[SLEN-2:SMAN_W]};
			mant = {val[SMAN_W-1:0], {(MAN_W-SMAN_W){1'b0}}};
			expMax = &val[SLEN-2:SMAN_W];
		end
	end

	assign opnd.sign = sgn;
	assign opnd.exponent = expo;
	assign opnd.mantissa = mant;

	// Zero padding keeps these tests the same for both formats
	assign expZero = (expo == '0);
	assign mantZero = (mant == '0);

	////////////////////////////////////////////////////////////
	// Special values
	////////////////////////////////////////////////////////////

	assign opnd.isNaN = expMax & ~mantZero;
	// Quiet bit is the top mantissa bit in both layouts
	assign opnd.isSNaN = expMax & ~mantZero & ~mant[MAN_W-1];
	assign opnd.isInf = expMax & mantZero;
	assign opnd.isZero = expZero & mantZero;
	assign opnd.isSubnorm = expZero & ~mantZero;

	// The possibly replaced register value, used for min/max and sign injection
	assign opnd.boxed = val;

endmodule

// ==== verilog/fpuMiscPkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, opcodes, operand and bus types for the FPU
// sign-injection, compare and classify block. Import it with a
// wildcard in the module header of every file that needs it.
////////////////////////////////////////////////////////////
package fpuMiscPkg;

	// Register widths fixed by the RISC-V F and D formats
	localparam int FLEN = 64;
	localparam int SLEN = 32;
	localparam int WBW = 32;

	// Field widths of the two formats
	localparam int EXP_W = 11;
	localparam int MAN_W = 52;
	localparam int SEXP_W = 8;
	localparam int SMAN_W = 23;

	// Canonical quiet NaNs, the single one already NaN-boxed
	localparam logic [FLEN-1:0] CNAN_D = 64'h7FF8_0000_0000_0000;
	localparam logic [FLEN-1:0] CNAN_S = 64'hFFFF_FFFF_7FC0_0000;

	////////////////////////////////////////////////////////////
	// Opcodes and formats
	////////////////////////////////////////////////////////////

	typedef enum logic {FMT_S = 1'b0, FMT_D = 1'b1} fpFmt_t;

	// Operation written to the control register
	typedef enum logic [3:0] {
		OP_FSGNJ = 4'd0,
		OP_FSGNJN = 4'd1,
		OP_FSGNJX = 4'd2,
		OP_FMIN = 4'd3,
		OP_FMAX = 4'd4,
		OP_FEQ = 4'd5,
		OP_FLT = 4'd6,
		OP_FLE = 4'd7,
		OP_FCLASS = 4'd8
	} fpOp_t;

	// Sub-opcodes seen by the result blocks
	typedef enum logic [1:0] {SGN_J = 2'd0, SGN_JN = 2'd1, SGN_JX = 2'd2} sgnOp_t;

	typedef enum logic [2:0] {
		CMP_EQ = 3'd0,
		CMP_LT = 3'd1,
		CMP_LE = 3'd2,
		CMP_MIN = 3'd3,
		CMP_MAX = 3'd4
	} cmpOp_t;

	////////////////////////////////////////////////////////////
	// Operand and bus structs
	////////////////////////////////////////////////////////////

	// A single operand keeps its exponent in the low 8 bits and its
	// mantissa in the top 23 bits so both formats order the same way
	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exponent;
		logic [MAN_W-1:0] mantissa;
		logic isNaN;
		logic isSNaN;
		logic isInf;
		logic isZero;
		logic isSubnorm;
		logic [FLEN-1:0] boxed;
	} fpOperand_t;

	// Wishbone classic request from the master, word addressed
	typedef struct packed {
		logic [3:0] adr;
		logic [WBW-1:0] dat;
		logic we;
		logic cyc;
		logic stb;
	} wbReq_t;

	// Register map, unmapped words read zero
	typedef enum logic [3:0] {
		R_XLO = 4'd0,
		R_XHI = 4'd1,
		R_YLO = 4'd2,
		R_YHI = 4'd3,
		R_CTRL = 4'd4,
		R_RESLO = 4'd5,
		R_RESHI = 4'd6,
		R_FLAGS = 4'd7
	} regAddr_t;

endpackage

// ==== verilog/fpuMiscWb.sv ====
////////////////////////////////////////////////////////////
// FPU sign-injection, compare and classify unit behind a
// Wishbone classic slave. Write X, Y, then the control word;
// the result and NV are readable from the next access on
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fpuMiscWb import fpuMiscPkg::*; (
	input logic clk,
	input logic rstN,
	input wbReq_t wbReq,
	output logic wbAck,
	output logic [WBW-1:0] wbDatOut
);

	// Which result block feeds the result register
	typedef enum logic [1:0] {
		U_SGN = 2'd0,
		U_CMP = 2'd1,
		U_CLASS = 2'd2,
		U_NONE = 2'd3
	} unitSel_t;

	logic [FLEN-1:0] xReg;
	logic [FLEN-1:0] yReg;
	fpOp_t op;
	fpFmt_t fmt;
	logic [FLEN-1:0] resReg;
	logic nvReg;
	logic launch;

	regAddr_t adr;
	logic reqValid;
	logic wrEn;

	fpOperand_t xOpnd;
	fpOperand_t yOpnd;
	unitSel_t unitSel;
	sgnOp_t sgnOp;
	cmpOp_t cmpOp;
	logic [FLEN-1:0] sgnRes;
	logic [FLEN-1:0] cmpRes;
	logic [FLEN-1:0] classRes;
	logic cmpInvalid;
	logic [FLEN-1:0] resNext;
	logic nvNext;

	////////////////////////////////////////////////////////////
	// Wishbone handshake
	////////////////////////////////////////////////////////////

	assign adr = regAddr_t'(wbReq.adr);

	// A new request is one the slave has not acked yet
	assign reqValid = wbReq.cyc & wbReq.stb & ~wbAck;
	assign wrEn = reqValid & wbReq.we;

	// Single-cycle ack one clock after the request appears
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= reqValid;
		end
	end

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			xReg <= '0;
			yReg <= '0;
			op <= OP_FSGNJ;
			fmt <= FMT_S;
			launch <= 1'b0;
		end else begin
			// Control write starts the operation one clock later
			launch <= wrEn & (adr == R_CTRL);
			if (wrEn) begin
				case (adr)
					R_XLO: xReg[WBW-1:0] <= wbReq.dat;
					R_XHI: xReg[FLEN-1:WBW] <= wbReq.dat;
					R_YLO: yReg[WBW-1:0] <= wbReq.dat;
					R_YHI: yReg[FLEN-1:WBW] <= wbReq.dat;
					R_CTRL: begin
						op <= fpOp_t'(wbReq.dat[3:0]);
						fmt <= fpFmt_t'(wbReq.dat[4]);
					end
					default: ;
				endcase
			end
		end
	end

	// Only a launch touches the result, operand writes leave it alone
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resReg <= '0;
			nvReg <= 1'b0;
		end else if (launch) begin
			resReg <= resNext;
			nvReg <= nvNext;
		end
	end

	// Read data follows the held address and is sampled with ack
	always_comb begin
		case (adr)
			R_XLO: wbDatOut = xReg[WBW-1:0];
			R_XHI: wbDatOut = xReg[FLEN-1:WBW];
			R_YLO: wbDatOut = yReg[WBW-1:0];
			R_YHI: wbDatOut = yReg[FLEN-1:WBW];
			R_CTRL: wbDatOut = {{(WBW-5){1'b0}}, fmt, op};
			R_RESLO: wbDatOut = resReg[WBW-1:0];
			R_RESHI: wbDatOut = resReg[FLEN-1:WBW];
			R_FLAGS: wbDatOut = {{(WBW-1){1'b0}}, nvReg};
			default: wbDatOut = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Operation decode
	////////////////////////////////////////////////////////////

	always_comb begin
		unitSel = U_NONE;
		sgnOp = SGN_J;
		cmpOp = CMP_EQ;
		case (op)
			OP_FSGNJ: unitSel = U_SGN;
			OP_FSGNJN: begin
				unitSel = U_SGN;
				sgnOp = SGN_JN;
			end
			OP_FSGNJX: begin
				unitSel = U_SGN;
				sgnOp = SGN_JX;
			end
			OP_FMIN: begin
				unitSel = U_CMP;
				cmpOp = CMP_MIN;
			end
			OP_FMAX: begin
				unitSel = U_CMP;
				cmpOp = CMP_MAX;
			end
			OP_FEQ: unitSel = U_CMP;
			OP_FLT: begin
				unitSel = U_CMP;
				cmpOp = CMP_LT;
			end
			OP_FLE: begin
				unitSel = U_CMP;
				cmpOp = CMP_LE;
			end
			OP_FCLASS: unitSel = U_CLASS;
			// Reserved opcodes give zero without NV
			default: unitSel = U_NONE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	fpUnpack i_unpackX (.src(xReg), .fmt(fmt), .opnd(xOpnd));
	fpUnpack i_unpackY (.src(yReg), .fmt(fmt), .opnd(yOpnd));

	// X's boxed value carries the canonical NaN for a broken box
	fsgninj i_fsgninj (
		.xSign(xOpnd.sign),
		.ySign(yOpnd.sign),
		.srcX(xOpnd.boxed),
		.fmt(fmt),
		.sgnOp(sgnOp),
		.sgnRes(sgnRes)
	);

	fcmp i_fcmp (
		.x(xOpnd),
		.y(yOpnd),
		.cmpOp(cmpOp),
		.cmpRes(cmpRes),
		.invalid(cmpInvalid)
	);

	fclassify i_fclassify (.x(xOpnd), .classRes(classRes));

	// Only the compare unit can signal invalid
	always_comb begin
		case (unitSel)
			U_SGN: resNext = sgnRes;
			U_CMP: resNext = cmpRes;
			U_CLASS: resNext = classRes;
			default: resNext = '0;
		endcase
		nvNext = (unitSel == U_CMP) & cmpInvalid;
	end

endmodule

// ==== verilog/fsgninj.sv ====
////////////////////////////////////////////////////////////
// Sign injection for fsgnj, fsgnjn and fsgnjx. Combinational;
// single results come back NaN-boxed
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fsgninj import fpuMiscPkg::*; (
	input logic xSign,
	input logic ySign,
	input logic [FLEN-1:0] srcX,
	input fpFmt_t fmt,
	input sgnOp_t sgnOp,
	output logic [FLEN-1:0] sgnRes
);

	logic resSgn;

	// Result sign
	//   SGN_J copies Y's sign
	//   SGN_JN takes its inverse
	//   SGN_JX xors both signs
	always_comb begin
		case (sgnOp)
			SGN_J: resSgn = ySign;
			SGN_JN: resSgn = ~ySign;
			SGN_JX: resSgn = xSign ^ ySign;
			default: resSgn = ySign;
		endcase
	end

	// Put the new sign on X's magnitude at the format's sign bit
	always_comb begin
		if (fmt == FMT_D) begin
			sgnRes = {resSgn, srcX[FLEN-2:0]};
		end else begin
			// Upper word filled with ones for the NaN-box
			sgnRes = {{(FLEN-SLEN){1'b1}}, resSgn, srcX[SLEN-2:0]};
		end
	end

endmodule
